// File: files.f
+incdir+.
sprite_pkg.sv
dpram.sv
sprite_line_buffer.sv
sprite_renderer.sv
sprite_engine_top.sv
sprite_engine_assert.sv
sprite_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sprite_engine_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') sprite_defs.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sprite_engine_tb.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_engine_tb;

    localparam int WIDTH         = `SPRITE_LINE_WIDTH;
    localparam int COUNT         = `SPRITE_COUNT;
    localparam int SIZE          = `SPRITE_SIZE;
    localparam int ERASE_CYCLES  = `SPRITE_BANK_WORDS;
    // Worst case per line with table load, render, full sweep and erase
    localparam int LINE_CYCLES   = 1250;
    localparam int LINE_OPS      = 12;
    localparam int TIMEOUT_LIMIT = LINE_OPS * LINE_CYCLES;

    logic                     clk;
    logic                     rst;
    logic                     attr_wr_en;
    logic [`SPRITE_IDX_W-1:0] attr_wr_idx;
    sprite_pkg::sprite_attr_t attr_wr_data;
    logic                     line_req;
    logic [`LINE_NUM_W-1:0]   line_num;
    logic                     line_ack;
    logic [`PIXEL_IDX_W-1:0]  composer_rd_idx;
    sprite_pkg::pixel_t       composer_rd_data;
    logic                     composer_erase_start;
    logic                     composer_erase_busy;

    sprite_pkg::sprite_attr_t mirror [COUNT];
    sprite_pkg::sprite_attr_t disp_attr [COUNT];
    logic [`LINE_NUM_W-1:0]   line_num_disp;
    logic [31:0]              lfsr_state;
    int                       cycle_count;

    // Sweep bookkeeping for the compare process
    logic                     sweep_valid;
    logic                     sweep_zero;
    logic                     pend_valid;
    logic                     pend_zero;
    logic [`PIXEL_IDX_W-1:0]  pend_idx;

    sprite_engine_top i_dut (
        .clk                  (clk),
        .rst                  (rst),
        .attr_wr_en           (attr_wr_en),
        .attr_wr_idx          (attr_wr_idx),
        .attr_wr_data         (attr_wr_data),
        .line_req             (line_req),
        .line_num             (line_num),
        .line_ack             (line_ack),
        .composer_rd_idx      (composer_rd_idx),
        .composer_rd_data     (composer_rd_data),
        .composer_erase_start (composer_erase_start),
        .composer_erase_busy  (composer_erase_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout waiting for line_ack or erase");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and random source
    ////////////////////////////////////////////////////////////////////////////

    // Front sprite is the lowest index with an opaque color over the pixel
    function automatic sprite_pkg::pixel_t expected_pixel(int line, int idx);
        sprite_pkg::sprite_attr_t a;
        for (int s = 0; s < COUNT; s++) begin
            a = disp_attr[s];
            if (a.enable && a.color != '0 && line >= int'(a.y) && line < int'(a.y) + SIZE &&
                idx >= int'(a.x) && idx < int'(a.x) + SIZE) begin
                return a.color;
            end
        end
        return '0;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare_pixel(input string name, input sprite_pkg::pixel_t exp,
                                 input sprite_pkg::pixel_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s expected %0d actual %0d",
                               $time, name, exp, act));
        end
    endtask

    // Index captured at the read edge and data checked at the next falling edge
    always @(posedge clk) begin
        pend_valid <= sweep_valid;
        pend_zero  <= sweep_zero;
        pend_idx   <= composer_rd_idx;
    end

    always @(negedge clk) begin
        if (pend_valid) begin
            compare_pixel($sformatf("composer_rd_data[%0d]", pend_idx),
                          pend_zero ? '0 : expected_pixel(int'(line_num_disp), int'(pend_idx)),
                          composer_rd_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_attr(input int idx, input sprite_pkg::sprite_attr_t a);
        @(negedge clk);
        attr_wr_en   = 1'b1;
        attr_wr_idx  = idx[`SPRITE_IDX_W-1:0];
        attr_wr_data = a;
        mirror[idx]  = a;
        @(negedge clk);
        attr_wr_en   = 1'b0;
    endtask

    task automatic clear_table();
        for (int s = 0; s < COUNT; s++) begin
            write_attr(s, '0);
        end
    endtask

    // Tops spread up to 31 lines above so about half the sprites cover the line
    task automatic random_table(input logic [7:0] line);
        sprite_pkg::sprite_attr_t a;
        logic [31:0]              v;
        for (int s = 0; s < COUNT; s++) begin
            v = draw(10);
            a.x = 10'(v % 650);
            v = draw(5);
            a.y = line - 8'(v);
            v = draw(3);
            a.enable = (v != 0);
            v = draw(3);
            if (v == 0) begin
                a.color = '0;
            end else begin
                v = draw(16);
                a.color = v[15:0];
            end
            write_attr(s, a);
        end
    endtask

    task automatic finish_request(input logic [7:0] line);
        while (!line_ack) begin
            @(negedge clk);
        end
        line_req = 1'b0;
        while (line_ack) begin
            @(negedge clk);
        end
        disp_attr     = mirror;
        line_num_disp = line;
    endtask

    task automatic request_line(input logic [7:0] line);
        @(negedge clk);
        line_num = line;
        line_req = 1'b1;
        finish_request(line);
    endtask

    task automatic erase_display();
        int n;
        @(negedge clk);
        composer_erase_start = 1'b1;
        @(negedge clk);
        composer_erase_start = 1'b0;
        n = 0;
        while (composer_erase_busy) begin
            n++;
            @(negedge clk);
        end
        compare_count("composer_erase_busy cycles", ERASE_CYCLES, n);
    endtask

    // Request raised while the erase runs so the renderer has to wait
    task automatic erase_and_request(input logic [7:0] line);
        @(negedge clk);
        composer_erase_start = 1'b1;
        @(negedge clk);
        composer_erase_start = 1'b0;
        line_num = line;
        line_req = 1'b1;
        compare_bit("composer_erase_busy", 1'b1, composer_erase_busy);
        while (composer_erase_busy) begin
            compare_bit("line_ack", 1'b0, line_ack);
            @(negedge clk);
        end
        finish_request(line);
    endtask

    task automatic sweep_display(input logic zero);
        sweep_zero = zero;
        for (int i = 0; i < WIDTH; i++) begin
            @(negedge clk);
            composer_rd_idx = i[`PIXEL_IDX_W-1:0];
            sweep_valid     = 1'b1;
        end
        @(negedge clk);
        sweep_valid = 1'b0;
    endtask

    // Display half is read while the next line renders up to the swap
    task automatic request_during_sweep(input logic [7:0] line);
        int  idx;
        logic done;
        @(negedge clk);
        line_num        = line;
        line_req        = 1'b1;
        sweep_zero      = 1'b0;
        idx             = 0;
        composer_rd_idx = '0;
        sweep_valid     = 1'b1;
        done            = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (line_ack || idx == WIDTH - 1) begin
                sweep_valid = 1'b0;
                done        = 1'b1;
            end else begin
                idx++;
                composer_rd_idx = idx[`PIXEL_IDX_W-1:0];
            end
        end
        finish_request(line);
    endtask

    task automatic build_table(input logic [7:0] line, input int sel);
        sprite_pkg::sprite_attr_t a;
        clear_table();
        a.enable = 1'b1;
        a.y      = line - 8'd3;
        if (sel == 0) begin
            // Transparent sprite on top of three overlapping opaque ones
            a.x     = 10'd100;
            a.color = 16'h0000;
            write_attr(0, a);
            a.x     = 10'd104;
            a.color = 16'h1111;
            write_attr(1, a);
            a.x     = 10'd96;
            a.color = 16'h2222;
            write_attr(2, a);
            a.x     = 10'd100;
            a.color = 16'h3333;
            write_attr(3, a);
        end else begin
            // Right edge clipping and an off-screen sprite
            a.x     = 10'd630;
            a.color = 16'haaaa;
            write_attr(0, a);
            a.x     = 10'd620;
            a.color = 16'hbbbb;
            write_attr(1, a);
            a.x     = 10'd1000;
            a.color = 16'hcccc;
            write_attr(2, a);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] v;
        rst                  = 1'b1;
        attr_wr_en           = 1'b0;
        attr_wr_idx          = '0;
        attr_wr_data         = '0;
        line_req             = 1'b0;
        line_num             = '0;
        composer_rd_idx      = '0;
        composer_erase_start = 1'b0;
        sweep_valid          = 1'b0;
        sweep_zero           = 1'b0;
        line_num_disp        = '0;
        lfsr_state           = 32'hf749;
        for (int s = 0; s < COUNT; s++) begin
            mirror[s]    = '0;
            disp_attr[s] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_bit("line_ack", 1'b0, line_ack);
        compare_bit("composer_erase_busy", 1'b0, composer_erase_busy);

        // Clear both halves
        erase_display();
        clear_table();
        request_line(8'd0);
        erase_display();
        sweep_display(1'b1);

        for (int n = 0; n < 6; n++) begin
            v = draw(8);
            random_table(v[7:0]);
            if (n % 2 == 1) begin
                erase_and_request(v[7:0]);
            end else begin
                erase_display();
                request_line(v[7:0]);
            end
            sweep_display(1'b0);
        end

        build_table(8'd40, 0);
        erase_and_request(8'd40);
        sweep_display(1'b0);
        build_table(8'd200, 1);
        erase_and_request(8'd200);
        sweep_display(1'b0);

        // Line N stays visible while N+1 renders
        random_table(8'd77);
        erase_and_request(8'd77);
        sweep_display(1'b0);
        random_table(8'd78);
        request_during_sweep(8'd78);
        sweep_display(1'b0);
        erase_display();
        sweep_display(1'b1);
        clear_table();
        request_line(8'd79);
        erase_display();
        sweep_display(1'b1);

        @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: sprite_engine_assert.sv
`timescale 1ns/1ps

module sprite_engine_assert (
    input logic clk,
    input logic rst,
    input logic line_req,
    input logic line_ack,
    input logic renderer_wr_en,
    input logic composer_erase_start,
    input logic composer_erase_busy
);

    // Four-phase handshake order
    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(line_ack) |-> $past(line_req))
        else $error("line_ack rose without line_req");

    a_ack_hold: assert property (@(posedge clk) disable iff (rst)
        line_ack && line_req |=> line_ack)
        else $error("line_ack dropped before line_req");

    // Renderer stays out of the buffers during an erase
    a_no_write: assert property (@(posedge clk) disable iff (rst)
        composer_erase_busy |-> !renderer_wr_en)
        else $error("renderer write during erase");

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        composer_erase_busy |-> !composer_erase_start)
        else $error("erase started while busy");

endmodule

bind sprite_engine_top sprite_engine_assert i_assert (
    .clk                  (clk),
    .rst                  (rst),
    .line_req             (line_req),
    .line_ack             (line_ack),
    .renderer_wr_en       (renderer_wr_en),
    .composer_erase_start (composer_erase_start),
    .composer_erase_busy  (composer_erase_busy)
);

// File: sprite_engine_top.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_engine_top (
    input  logic                     clk,
    input  logic                     rst,

    // Host attribute port
    input  logic                     attr_wr_en,
    input  logic [`SPRITE_IDX_W-1:0] attr_wr_idx,
    input  sprite_pkg::sprite_attr_t attr_wr_data,

    // Line request
    input  logic                     line_req,
    input  logic [`LINE_NUM_W-1:0]   line_num,
    output logic                     line_ack,

    // Compositor port
    input  logic [`PIXEL_IDX_W-1:0]  composer_rd_idx,
    output sprite_pkg::pixel_t       composer_rd_data,
    input  logic                     composer_erase_start,
    output logic                     composer_erase_busy
);

    logic [`SPRITE_IDX_W-1:0] attr_rd_idx;
    sprite_pkg::sprite_attr_t attr_rd_data;
    logic [`PIXEL_IDX_W-1:0]  renderer_rd_idx;
    sprite_pkg::pixel_t       renderer_rd_data;
    logic [`PIXEL_IDX_W-1:0]  renderer_wr_idx;
    sprite_pkg::pixel_t       renderer_wr_data;
    logic                     renderer_wr_en;
    logic                     active_render_buffer;

    // Sprite attribute table
    dpram #(
        .payload_t (sprite_pkg::sprite_attr_t),
        .DEPTH     (`SPRITE_COUNT)
    ) i_attr_table (
        .clk     (clk),
        .wr_en   (attr_wr_en),
        .wr_addr (attr_wr_idx),
        .wr_data (attr_wr_data),
        .rd_addr (attr_rd_idx),
        .rd_data (attr_rd_data)
    );

    sprite_renderer i_renderer (
        .clk                  (clk),
        .rst                  (rst),
        .line_req             (line_req),
        .line_num             (line_num),
        .line_ack             (line_ack),
        .attr_rd_idx          (attr_rd_idx),
        .attr_rd_data         (attr_rd_data),
        .renderer_rd_idx      (renderer_rd_idx),
        .renderer_rd_data     (renderer_rd_data),
        .renderer_wr_idx      (renderer_wr_idx),
        .renderer_wr_data     (renderer_wr_data),
        .renderer_wr_en       (renderer_wr_en),
        .composer_erase_busy  (composer_erase_busy),
        .active_render_buffer (active_render_buffer)
    );

    sprite_line_buffer i_line_buffer (
        .clk                  (clk),
        .rst                  (rst),
        .active_render_buffer (active_render_buffer),
        .renderer_rd_idx      (renderer_rd_idx),
        .renderer_rd_data     (renderer_rd_data),
        .renderer_wr_idx      (renderer_wr_idx),
        .renderer_wr_data     (renderer_wr_data),
        .renderer_wr_en       (renderer_wr_en),
        .composer_rd_idx      (composer_rd_idx),
        .composer_rd_data     (composer_rd_data),
        .composer_erase_start (composer_erase_start),
        .composer_erase_busy  (composer_erase_busy)
    );

endmodule

// File: sprite_renderer.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_renderer (
    input  logic                     clk,
    input  logic                     rst,

    // Line request
    input  logic                     line_req,
    input  logic [`LINE_NUM_W-1:0]   line_num,
    output logic                     line_ack,

    // Attribute table
    output logic [`SPRITE_IDX_W-1:0] attr_rd_idx,
    input  sprite_pkg::sprite_attr_t attr_rd_data,

    // Line buffer
    output logic [`PIXEL_IDX_W-1:0]  renderer_rd_idx,
    input  sprite_pkg::pixel_t       renderer_rd_data,
    output logic [`PIXEL_IDX_W-1:0]  renderer_wr_idx,
    output sprite_pkg::pixel_t       renderer_wr_data,
    output logic                     renderer_wr_en,
    input  logic                     composer_erase_busy,
    output logic                     active_render_buffer
);

    localparam int PIX_W  = `PIXEL_IDX_W;
    localparam int SPR_W  = `SPRITE_IDX_W;
    localparam int LINE_W = `LINE_NUM_W;
    localparam int CNT_W  = $clog2(`SPRITE_SIZE);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPRITE_SIZE - 1);
    localparam logic [PIX_W-1:0] COL_LAST = PIX_W'(`SPRITE_LINE_WIDTH - 1);
    localparam logic [SPR_W-1:0] SPR_LAST = SPR_W'(`SPRITE_COUNT - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_CHECK,
        S_SCAN,
        S_DONE,
        S_ACK
    } state_t;

    state_t             state;
    logic [SPR_W-1:0]   spr_idx;
    logic [PIX_W-1:0]   col;
    logic [CNT_W-1:0]   cnt;
    sprite_pkg::pixel_t color;
    logic               rd_pend;
    logic [PIX_W-1:0]   pend_idx;
    logic [LINE_W-1:0]  line_off;
    logic               covers;
    logic               scan_end;
    logic               last_sprite;

    // Entry covers the line and starts on screen
    assign line_off = line_num - attr_rd_data.y;
    assign covers   = attr_rd_data.enable && line_num >= attr_rd_data.y &&
                      line_off < LINE_W'(`SPRITE_SIZE) &&
                      attr_rd_data.x < PIX_W'(`SPRITE_LINE_WIDTH);

    assign scan_end    = (cnt == CNT_LAST) || (col == COL_LAST);
    assign last_sprite = (spr_idx == SPR_LAST);

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                <= S_IDLE;
            spr_idx              <= '0;
            rd_pend              <= 1'b0;
            line_ack             <= 1'b0;
            active_render_buffer <= 1'b0;
        end else begin
            rd_pend <= (state == S_SCAN);
            case (state)
                S_IDLE: begin
                    if (line_req && !composer_erase_busy) begin
                        spr_idx <= '0;
                        state   <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_CHECK;
                end
                S_CHECK: begin
                    if (covers) begin
                        // Hold the entry until the erase is over
                        if (!composer_erase_busy) begin
                            state <= S_SCAN;
                        end
                    end else if (last_sprite) begin
                        state <= S_DONE;
                    end else begin
                        spr_idx <= spr_idx + 1'b1;
                        state   <= S_FETCH;
                    end
                end
                S_SCAN: begin
                    if (scan_end && last_sprite) begin
                        state <= S_DONE;
                    end else if (scan_end) begin
                        spr_idx <= spr_idx + 1'b1;
                        state   <= S_FETCH;
                    end
                end
                S_DONE: begin
                    // Last pending write lands on this edge too
                    active_render_buffer <= ~active_render_buffer;
                    line_ack             <= 1'b1;
                    state                <= S_ACK;
                end
                S_ACK: begin
                    if (!line_req) begin
                        line_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        pend_idx <= col;
        if (state == S_CHECK) begin
            col   <= attr_rd_data.x;
            cnt   <= '0;
            color <= attr_rd_data.color;
        end else if (state == S_SCAN) begin
            col <= col + 1'b1;
            cnt <= cnt + 1'b1;
        end
    end

    assign attr_rd_idx     = spr_idx;
    assign renderer_rd_idx = col;

    // Write only into empty pixels, earlier sprites stay in front
    assign renderer_wr_idx  = pend_idx;
    assign renderer_wr_data = color;
    assign renderer_wr_en   = rd_pend && renderer_rd_data == '0 && color != '0;

endmodule

// File: sprite_line_buffer.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_line_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    active_render_buffer,

    // Renderer side
    input  logic [`PIXEL_IDX_W-1:0] renderer_rd_idx,
    output sprite_pkg::pixel_t      renderer_rd_data,
    input  logic [`PIXEL_IDX_W-1:0] renderer_wr_idx,
    input  sprite_pkg::pixel_t      renderer_wr_data,
    input  logic                    renderer_wr_en,

    // Compositor side
    input  logic [`PIXEL_IDX_W-1:0] composer_rd_idx,
    output sprite_pkg::pixel_t      composer_rd_data,
    input  logic                    composer_erase_start,
    output logic                    composer_erase_busy
);

    localparam int PIX_W      = `PIXEL_IDX_W;
    localparam int BANK_W     = $clog2(`SPRITE_BANKS);
    localparam int WORD_W     = PIX_W - BANK_W;
    localparam int BANK_WORDS = `SPRITE_BANK_WORDS;

    localparam logic [WORD_W-1:0] ERASE_LAST = WORD_W'(BANK_WORDS - 1);

    logic [WORD_W-1:0]  erase_addr;
    logic               active_q;
    sprite_pkg::pixel_t buf_rd_data [2];

    ////////////////////////////////////////////////////////////////////////////
    // Erase engine
    ////////////////////////////////////////////////////////////////////////////

    // One word address per clock, all four banks of the display half at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            composer_erase_busy <= 1'b0;
            erase_addr          <= '0;
        end else if (composer_erase_busy) begin
            if (erase_addr == ERASE_LAST) begin
                composer_erase_busy <= 1'b0;
            end
            erase_addr <= erase_addr + 1'b1;
        end else if (composer_erase_start) begin
            composer_erase_busy <= 1'b1;
            erase_addr          <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Line buffers
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < 2; b++) begin : g_buf
        logic               is_render;
        logic [PIX_W-1:0]   rd_idx;
        logic [WORD_W-1:0]  wr_word;
        sprite_pkg::pixel_t wr_data;
        logic [BANK_W-1:0]  sel_q;
        sprite_pkg::pixel_t bank_rd [`SPRITE_BANKS];

        // Buffer b belongs to the renderer when the select matches its number
        assign is_render = (active_render_buffer == 1'(b));

        assign rd_idx  = is_render ? renderer_rd_idx : composer_rd_idx;
        assign wr_word = is_render ? renderer_wr_idx[PIX_W-1:BANK_W] : erase_addr;
        assign wr_data = is_render ? renderer_wr_data : '0;

        // Low index bits pick the bank
        for (genvar k = 0; k < `SPRITE_BANKS; k++) begin : g_bank
            logic wr_en;

            assign wr_en = is_render
                ? (renderer_wr_en && renderer_wr_idx[BANK_W-1:0] == BANK_W'(k))
                : composer_erase_busy;

            dpram #(
                .payload_t (sprite_pkg::pixel_t),
                .DEPTH     (BANK_WORDS)
            ) i_bank (
                .clk     (clk),
                .wr_en   (wr_en),
                .wr_addr (wr_word),
                .wr_data (wr_data),
                .rd_addr (rd_idx[PIX_W-1:BANK_W]),
                .rd_data (bank_rd[k])
            );
        end

        // Bank select follows the RAM read by one cycle
        always_ff @(posedge clk) begin
            sel_q <= rd_idx[BANK_W-1:0];
        end

        assign buf_rd_data[b] = bank_rd[sel_q];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data steering
    ////////////////////////////////////////////////////////////////////////////

    // Select as it was when the index was presented
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
        end else begin
            active_q <= active_render_buffer;
        end
    end

    assign renderer_rd_data = buf_rd_data[active_q];
    assign composer_rd_data = buf_rd_data[~active_q];

endmodule

// File: dpram.sv
`timescale 1ns/1ps
`include "sprite_defs.svh"

module dpram #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = `SPRITE_BANK_WORDS
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    // Read returns old contents on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: sprite_pkg.sv
`include "sprite_defs.svh"

package sprite_pkg;

    // One color word, zero is transparent or empty
    typedef logic [15:0] pixel_t;

    // Attribute table entry, 35 bits
    typedef struct packed {
        logic                    enable;
        logic [`PIXEL_IDX_W-1:0] x;
        logic [`LINE_NUM_W-1:0]  y;
        pixel_t                  color;
    } sprite_attr_t;

endpackage

// File: sprite_defs.svh
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// Visible pixels per line
`define SPRITE_LINE_WIDTH 640

// Interleaved banks per line buffer
`define SPRITE_BANKS 4

// Words per bank, follows from width and bank count
`define SPRITE_BANK_WORDS (`SPRITE_LINE_WIDTH / `SPRITE_BANKS)

// Attribute table entries
`define SPRITE_COUNT 16

// Sprite width and height in pixels
`define SPRITE_SIZE 16

// Index widths
`define PIXEL_IDX_W 10
`define SPRITE_IDX_W 4
`define LINE_NUM_W 8

`endif
